// ==== verilog/mem_pkg.sv ====
// Memory geometry, word type and the read and write request structs

package mem_pkg;

    // -------------------------------------------------------------------------
    // Geometry
    // -------------------------------------------------------------------------

    // Width of one stored word
    localparam int DATA_WID     = 16;
    // Word address width
    localparam int ADDR_WID     = 6;
    // Number of words in the array
    localparam int MEM_DEPTH    = 64;
    // Cycles from read issue to landed data
    localparam int READ_LATENCY = 3;

    // -------------------------------------------------------------------------
    // Types
    // -------------------------------------------------------------------------

    typedef logic [DATA_WID-1:0] data_t;

    // Host write request, qualified by a separate strobe
    typedef struct packed {
        logic [ADDR_WID-1:0] addr;
        data_t               data;
    } mem_wr_t;

    // Read request, en marks a read issued this cycle
    typedef struct packed {
        logic                en;
        logic [ADDR_WID-1:0] addr;
    } mem_rd_t;

endpackage : mem_pkg

// ==== verilog/prefetch_pkg.sv ====
// Fetch command format and sequencer state encoding for the prefetcher

package prefetch_pkg;

    // -------------------------------------------------------------------------
    // Command
    // -------------------------------------------------------------------------

    // Word count width, one more bit than the address so a full sweep fits
    localparam int LEN_WID = 7;

    // One fetch request from the host
    typedef struct packed {
        logic [mem_pkg::ADDR_WID-1:0] addr;
        logic [LEN_WID-1:0]           len;
    } fetch_cmd_t;

    // -------------------------------------------------------------------------
    // Sequencer states
    // -------------------------------------------------------------------------

    // IDLE waits for a command, ISSUE sends reads, DRAIN waits for landings
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ISSUE = 2'd1,
        DRAIN = 2'd2
    } fetch_state_t;

endpackage : prefetch_pkg

// ==== verilog/fifo_prefetch.sv ====
// Prefetch FIFO with a fall-through read port and write reservation for reads in flight
module fifo_prefetch #(
    parameter int DATA_WID       = 16,
    // Writes that may still arrive after wr_rdy drops
    parameter int PIPELINE_DEPTH = 3
) (
    input  logic                clk,
    input  logic                srst,
    // Write side
    input  logic                wr,
    output logic                wr_rdy,
    input  logic [DATA_WID-1:0] wr_data,
    // Read side
    input  logic                rd,
    output logic                rd_vld,
    output logic [DATA_WID-1:0] rd_data,
    output logic                oflow
);
    // -------------------------------------------------------------------------
    // Geometry
    // -------------------------------------------------------------------------

    // Two reserve windows plus write-to-count and output load slack
    localparam int DEPTH   = 2 * PIPELINE_DEPTH + 3;
    localparam int PTR_WID = $clog2(DEPTH);
    localparam int CNT_WID = $clog2(DEPTH + 1);
    localparam int RSV_WID = $clog2(PIPELINE_DEPTH + 1);
    // Room for array count, output word and all reservations together
    localparam int SUM_WID = $clog2(DEPTH + PIPELINE_DEPTH + 2);

    logic [DATA_WID-1:0]       mem [DEPTH];
    logic [PTR_WID-1:0]        wr_ptr;
    logic [PTR_WID-1:0]        rd_ptr;
    // Words held in the array, output register excluded
    logic [CNT_WID-1:0]        mem_count;
    // One bit per recent cycle in which wr_rdy was granted
    logic [PIPELINE_DEPTH-1:0] rdy_vec;
    logic [RSV_WID-1:0]        reserved;
    logic [SUM_WID-1:0]        occupied;
    logic                      do_wr;
    logic                      pop;
    logic                      load_out;

    function automatic logic [PTR_WID-1:0] next_ptr(input logic [PTR_WID-1:0] ptr);
        return (ptr == PTR_WID'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    function automatic logic [RSV_WID-1:0] count_ones(input logic [PIPELINE_DEPTH-1:0] vec);
        logic [RSV_WID-1:0] n;
        n = '0;
        for (int i = 0; i < PIPELINE_DEPTH; i++) begin
            n = n + RSV_WID'(vec[i]);
        end
        return n;
    endfunction

    // -------------------------------------------------------------------------
    // Datapath control
    // -------------------------------------------------------------------------

    // Writes into a full array are dropped and flagged
    assign do_wr    = wr && (mem_count != CNT_WID'(DEPTH));
    assign pop      = rd && rd_vld;
    // Refill the output word when it is empty or leaving this cycle
    assign load_out = (mem_count != '0) && (!rd_vld || pop);

    // Each granted cycle may still have one write on its way
    assign reserved = count_ones(rdy_vec);
    assign occupied = SUM_WID'(mem_count) + SUM_WID'(rd_vld) + SUM_WID'(reserved);

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            mem_count <= '0;
            rd_vld    <= 1'b0;
            rdy_vec   <= '0;
            wr_rdy    <= 1'b0;
            oflow     <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (load_out) begin
                rd_ptr <= next_ptr(rd_ptr);
                rd_vld <= 1'b1;
            end else if (pop) begin
                rd_vld <= 1'b0;
            end
            case ({do_wr, load_out})
                2'b10:   mem_count <= mem_count + 1'b1;
                2'b01:   mem_count <= mem_count - 1'b1;
                default: mem_count <= mem_count;
            endcase
            // Age the grant history by one cycle
            rdy_vec <= (rdy_vec << 1) | PIPELINE_DEPTH'(wr_rdy);
            // Keep one slot spare beyond what the reservations claim
            wr_rdy  <= occupied < SUM_WID'(DEPTH - 1);
            oflow   <= wr && !do_wr;
        end
    end

    // Storage and output word carry no reset
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (load_out) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // -------------------------------------------------------------------------
    // Checks
    // -------------------------------------------------------------------------

    // Reservation keeps every landed write inside the array
    a_no_oflow: assert property (@(posedge clk) disable iff (srst) !oflow);

    // A pop of the last word leaves nothing to present next cycle
    a_empty_after_pop: assert property (@(posedge clk) disable iff (srst)
        pop && (mem_count == '0) |=> !rd_vld);

endmodule : fifo_prefetch

// ==== verilog/read_pipe.sv ====
// Word memory with a host write port and a fixed-latency registered read path
module read_pipe (
    input  logic             clk,
    input  logic             srst,
    // Host load port
    input  logic             mem_wr_en,
    input  mem_pkg::mem_wr_t mem_wr,
    // Read request from the fetch counter
    input  mem_pkg::mem_rd_t mem_rd,
    // Landed data toward the FIFO
    output logic             land_vld,
    output mem_pkg::data_t   land_data
);
    localparam int LAT = mem_pkg::READ_LATENCY;

    mem_pkg::data_t mem [mem_pkg::MEM_DEPTH];
    // Valid bit per stage, stage 0 is loaded from the request
    logic [LAT-1:0] vld_pipe;
    mem_pkg::data_t data_pipe [LAT];

    // -------------------------------------------------------------------------
    // Array and data stages
    // -------------------------------------------------------------------------

    // Host writes land in the array one edge later
    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            mem[mem_wr.addr] <= mem_wr.data;
        end
    end

    // First stage reads the array, later stages just carry the word
    always_ff @(posedge clk) begin
        if (mem_rd.en) begin
            data_pipe[0] <= mem[mem_rd.addr];
        end
        for (int i = 1; i < LAT; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    // -------------------------------------------------------------------------
    // Valid stages
    // -------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (srst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= (vld_pipe << 1) | LAT'(mem_rd.en);
        end
    end

    // Last stage feeds the FIFO write port
    assign land_vld  = vld_pipe[LAT-1];
    assign land_data = data_pipe[LAT-1];

    // -------------------------------------------------------------------------
    // Checks
    // -------------------------------------------------------------------------

    // Every issued read comes out exactly READ_LATENCY cycles later
    a_latency: assert property (@(posedge clk) disable iff (srst)
        land_vld == $past(mem_rd.en, LAT));

endmodule : read_pipe

// ==== verilog/fetch_counter.sv ====
// Address and word counters that track the issue and landing of one fetch
module fetch_counter (
    input  logic                     clk,
    input  logic                     srst,
    // Command capture from the sequencer
    input  logic                     load,
    input  prefetch_pkg::fetch_cmd_t cmd,
    // One strobe per read sent and per word landed
    input  logic                     issue,
    input  logic                     landed,
    output mem_pkg::mem_rd_t         mem_rd,
    output logic                     issue_last,
    output logic                     all_landed
);
    localparam int AW = mem_pkg::ADDR_WID;
    localparam int LW = prefetch_pkg::LEN_WID;

    logic [AW-1:0] next_addr;
    // Reads still to send
    logic [LW-1:0] issue_cnt;
    // Words still to arrive at the FIFO
    logic [LW-1:0] land_cnt;

    // -------------------------------------------------------------------------
    // Counters
    // -------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (srst) begin
            next_addr <= '0;
            issue_cnt <= '0;
            land_cnt  <= '0;
        end else if (load) begin
            next_addr <= cmd.addr;
            issue_cnt <= cmd.len;
            land_cnt  <= cmd.len;
        end else begin
            if (issue) begin
                // Step through memory and wrap at the top word
                next_addr <= (next_addr == AW'(mem_pkg::MEM_DEPTH - 1)) ? '0 : next_addr + 1'b1;
                issue_cnt <= issue_cnt - 1'b1;
            end
            if (landed) begin
                land_cnt <= land_cnt - 1'b1;
            end
        end
    end

    // Request goes out in the same cycle as the strobe
    assign mem_rd.en   = issue;
    assign mem_rd.addr = next_addr;

    assign issue_last  = (issue_cnt == LW'(1));
    assign all_landed  = (land_cnt == '0);

    // -------------------------------------------------------------------------
    // Checks
    // -------------------------------------------------------------------------

    // Sequencer and read path never ask for more than the command length
    a_no_underrun: assert property (@(posedge clk) disable iff (srst)
        !(issue && issue_cnt == '0) && !(landed && land_cnt == '0));

endmodule : fetch_counter

// ==== verilog/fetch_fsm.sv ====
// Fetch sequencer that takes commands, paces reads on FIFO headroom and reports completion
module fetch_fsm (
    input  logic                            clk,
    input  logic                            srst,
    // Host command strobe and its length
    input  logic                            cmd_start,
    input  logic [prefetch_pkg::LEN_WID-1:0] cmd_len,
    // Headroom from the prefetch FIFO
    input  logic                            wr_rdy,
    // Status from the fetch counter
    input  logic                            issue_last,
    input  logic                            all_landed,
    output logic                            load,
    output logic                            issue,
    output logic                            busy,
    output logic                            done
);
    prefetch_pkg::fetch_state_t state;
    prefetch_pkg::fetch_state_t state_nxt;
    logic                       done_nxt;

    // -------------------------------------------------------------------------
    // Strobes
    // -------------------------------------------------------------------------

    // Commands are only seen in IDLE, so one arriving while busy is dropped
    assign load  = (state == prefetch_pkg::IDLE) && cmd_start;
    // One read per cycle while the FIFO grants room
    assign issue = (state == prefetch_pkg::ISSUE) && wr_rdy;
    assign busy  = (state != prefetch_pkg::IDLE);

    // -------------------------------------------------------------------------
    // Next state
    // -------------------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        done_nxt  = 1'b0;
        unique case (state)
            prefetch_pkg::IDLE: begin
                // A zero length skips straight to the completion wait
                if (cmd_start) begin
                    state_nxt = (cmd_len == '0) ? prefetch_pkg::DRAIN : prefetch_pkg::ISSUE;
                end
            end
            prefetch_pkg::ISSUE: begin
                if (issue && issue_last) begin
                    state_nxt = prefetch_pkg::DRAIN;
                end
            end
            prefetch_pkg::DRAIN: begin
                // Last word is in the FIFO
                if (all_landed) begin
                    state_nxt = prefetch_pkg::IDLE;
                    done_nxt  = 1'b1;
                end
            end
            default: state_nxt = prefetch_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            state <= prefetch_pkg::IDLE;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            done  <= done_nxt;
        end
    end

    // No further read goes out once the last read of a command has been sent
    a_stop_after_last: assert property (@(posedge clk) disable iff (srst)
        issue && issue_last |=> !issue);

endmodule : fetch_fsm

// ==== verilog/mem_prefetch_top.sv ====
// Memory read prefetcher joining sequencer, counters, read pipeline and prefetch FIFO
module mem_prefetch_top (
    input  logic                     clk,
    input  logic                     srst,
    // Host memory load
    input  logic                     mem_wr_en,
    input  mem_pkg::mem_wr_t         mem_wr,
    // Fetch command
    input  logic                     cmd_start,
    input  prefetch_pkg::fetch_cmd_t cmd,
    output logic                     busy,
    output logic                     done,
    // Consumer side
    input  logic                     rd,
    output logic                     rd_vld,
    output mem_pkg::data_t           rd_data,
    output logic                     oflow
);
    logic             load;
    logic             issue;
    logic             issue_last;
    logic             all_landed;
    logic             wr_rdy;
    mem_pkg::mem_rd_t mem_rd;
    logic             land_vld;
    mem_pkg::data_t   land_data;

    // -------------------------------------------------------------------------
    // Sequencer and counters
    // -------------------------------------------------------------------------

    fetch_fsm u_fsm (
        .clk        (clk),
        .srst       (srst),
        .cmd_start  (cmd_start),
        .cmd_len    (cmd.len),
        .wr_rdy     (wr_rdy),
        .issue_last (issue_last),
        .all_landed (all_landed),
        .load       (load),
        .issue      (issue),
        .busy       (busy),
        .done       (done)
    );

    // Landed strobe closes the loop on words reaching the FIFO
    fetch_counter u_counter (
        .clk        (clk),
        .srst       (srst),
        .load       (load),
        .cmd        (cmd),
        .issue      (issue),
        .landed     (land_vld),
        .mem_rd     (mem_rd),
        .issue_last (issue_last),
        .all_landed (all_landed)
    );

    // -------------------------------------------------------------------------
    // Read path and buffer
    // -------------------------------------------------------------------------

    read_pipe u_read_pipe (
        .clk       (clk),
        .srst      (srst),
        .mem_wr_en (mem_wr_en),
        .mem_wr    (mem_wr),
        .mem_rd    (mem_rd),
        .land_vld  (land_vld),
        .land_data (land_data)
    );

    // Reserve depth matches the read latency
    fifo_prefetch #(
        .DATA_WID       (mem_pkg::DATA_WID),
        .PIPELINE_DEPTH (mem_pkg::READ_LATENCY)
    ) u_fifo (
        .clk     (clk),
        .srst    (srst),
        .wr      (land_vld),
        .wr_rdy  (wr_rdy),
        .wr_data (land_data),
        .rd      (rd),
        .rd_vld  (rd_vld),
        .rd_data (rd_data),
        .oflow   (oflow)
    );

endmodule : mem_prefetch_top

// ==== verification/tb_clock_gen.sv ====
// Testbench clock source and synchronous reset generator for the prefetcher
module tb_clock_gen #(
    parameter real PERIOD_NS    = 40.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clk,
    output logic srst
);
    timeunit 1ns;
    timeprecision 1ps;

    // Free-running clock, low at time zero
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Reset held high for the first few rising edges
    initial begin
        srst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        srst <= 1'b0;
    end

endmodule : tb_clock_gen

// ==== verification/mem_prefetch_tb.sv ====
// Table-driven testbench for the memory read prefetcher with a reference memory model
module mem_prefetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROWS      = 7;
    localparam int ROW_TIMEOUT   = 2000;
    localparam int RESET_TIMEOUT = 20;
    // Idle cycles after the last pop that must bring no further word
    localparam int TAIL_CYCLES   = 3;

    // One stimulus row, stall and gap counted in clock cycles
    typedef struct packed {
        logic [mem_pkg::ADDR_WID-1:0]     addr;
        logic [prefetch_pkg::LEN_WID-1:0] len;
        logic [7:0]                       stall;
        logic [3:0]                       gap;
        // Send a second command while busy
        logic                             extra;
    } row_t;

    logic                     clk;
    logic                     srst;
    logic                     mem_wr_en;
    mem_pkg::mem_wr_t         mem_wr;
    logic                     cmd_start;
    prefetch_pkg::fetch_cmd_t cmd;
    logic                     busy;
    logic                     done;
    logic                     rd;
    logic                     rd_vld;
    mem_pkg::data_t           rd_data;
    logic                     oflow;

    // Reference copy of the memory contents
    mem_pkg::data_t ref_mem [mem_pkg::MEM_DEPTH];
    row_t           rows [NUM_ROWS];
    int             seed;
    int             errors;

    tb_clock_gen u_clk_gen (
        .clk  (clk),
        .srst (srst)
    );

    mem_prefetch_top dut (
        .clk       (clk),
        .srst      (srst),
        .mem_wr_en (mem_wr_en),
        .mem_wr    (mem_wr),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .rd        (rd),
        .rd_vld    (rd_vld),
        .rd_data   (rd_data),
        .oflow     (oflow)
    );

    // ------------------------------------------------------------------------
    // Error reporting and compares
    // ------------------------------------------------------------------------

    task automatic report_error(input string line);
        $display("%s", line);
        errors++;
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input string name, input mem_pkg::data_t got,
                              input mem_pkg::data_t exp);
        if (got !== exp) begin
            report_error($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    // Setup
    // ------------------------------------------------------------------------

    // Streaming, wrap, back-pressure, pop gap, ignored command, zero length, full sweep
    task automatic load_table();
        rows[0] = '{addr: 6'd0,  len: 7'd8,  stall: 8'd0,  gap: 4'd0, extra: 1'b0};
        rows[1] = '{addr: 6'd60, len: 7'd10, stall: 8'd0,  gap: 4'd0, extra: 1'b0};
        rows[2] = '{addr: 6'd5,  len: 7'd40, stall: 8'd60, gap: 4'd0, extra: 1'b0};
        rows[3] = '{addr: 6'd17, len: 7'd12, stall: 8'd0,  gap: 4'd2, extra: 1'b0};
        rows[4] = '{addr: 6'd33, len: 7'd6,  stall: 8'd0,  gap: 4'd0, extra: 1'b1};
        rows[5] = '{addr: 6'd9,  len: 7'd0,  stall: 8'd0,  gap: 4'd0, extra: 1'b0};
        rows[6] = '{addr: 6'd0,  len: 7'd64, stall: 8'd0,  gap: 4'd1, extra: 1'b0};
    endtask

    task automatic wait_reset_release();
        int wait_cnt;
        wait_cnt = 0;
        while (srst) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > RESET_TIMEOUT) begin
                report_error("Timed out waiting for reset to be released");
            end
        end
    endtask

    // Random contents go into the array and the reference copy alike
    task automatic preload_memory();
        logic [31:0] rnd;
        for (int i = 0; i < mem_pkg::MEM_DEPTH; i++) begin
            rnd = $random(seed);
            ref_mem[i] = rnd[mem_pkg::DATA_WID-1:0];
        end
        for (int i = 0; i < mem_pkg::MEM_DEPTH; i++) begin
            @(posedge clk);
            mem_wr_en   <= 1'b1;
            mem_wr.addr <= i[mem_pkg::ADDR_WID-1:0];
            mem_wr.data <= ref_mem[i];
        end
        @(posedge clk);
        mem_wr_en <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // One table row
    // ------------------------------------------------------------------------

    // Outputs are sampled on the falling edge, inputs change on the rising edge
    task automatic run_row(input row_t row);
        int   cycle;
        int   n;
        int   stall_left;
        int   gap_left;
        int   post_cnt;
        bit   done_seen;
        bit   extra_sent;
        bit   send_extra;
        logic rd_next;
        cycle      = 0;
        n          = 0;
        stall_left = int'(row.stall);
        gap_left   = 0;
        post_cnt   = 0;
        done_seen  = 1'b0;
        extra_sent = 1'b0;
        @(posedge clk);
        cmd       <= '{addr: row.addr, len: row.len};
        cmd_start <= 1'b1;
        rd        <= 1'b0;
        while (post_cnt < TAIL_CYCLES) begin
            @(negedge clk);
            if (cycle > ROW_TIMEOUT) begin
                report_error("Timed out waiting for done and the expected words");
            end
            check_flag("oflow", oflow, 1'b0);
            if (row.len == '0) begin
                check_flag("rd_vld", rd_vld, 1'b0);
            end
            // busy rises one edge after the command and falls with done
            if (cycle == 0) begin
                check_flag("busy", busy, 1'b0);
                check_flag("done", done, 1'b0);
            end else if (done) begin
                if (done_seen) begin
                    report_error("done pulsed a second time for one command");
                end
                done_seen = 1'b1;
                check_flag("busy", busy, 1'b0);
            end else begin
                check_flag("busy", busy, !done_seen);
            end
            // Pop takes effect on the next rising edge
            if (rd && rd_vld) begin
                if (n >= int'(row.len)) begin
                    report_error("A word arrived beyond the requested length");
                end
                check_data("rd_data", rd_data,
                           ref_mem[(int'(row.addr) + n) % mem_pkg::MEM_DEPTH]);
                n++;
                gap_left = int'(row.gap);
            end
            if (stall_left > 0) begin
                stall_left--;
                rd_next = 1'b0;
            end else if (gap_left > 0) begin
                gap_left--;
                rd_next = 1'b0;
            end else begin
                rd_next = 1'b1;
            end
            // Second command only once the sequencer shows busy
            send_extra = row.extra && !extra_sent && busy && (cycle >= 2);
            if (done_seen && (n == int'(row.len))) begin
                post_cnt++;
            end
            @(posedge clk);
            rd <= rd_next;
            if (send_extra) begin
                cmd        <= '{addr: 6'h2a, len: 7'd20};
                cmd_start  <= 1'b1;
                extra_sent = 1'b1;
            end else begin
                cmd_start <= 1'b0;
            end
            cycle++;
        end
        // Everything popped, nothing left to present
        @(negedge clk);
        check_flag("rd_vld", rd_vld, 1'b0);
        check_flag("busy", busy, 1'b0);
        check_flag("oflow", oflow, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        seed      = 32'h4e80_6a37;
        errors    = 0;
        mem_wr_en = 1'b0;
        mem_wr    = '0;
        cmd_start = 1'b0;
        cmd       = '0;
        rd        = 1'b0;
        load_table();
        wait_reset_release();
        // Idle outputs straight after reset
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("rd_vld", rd_vld, 1'b0);
        check_flag("oflow", oflow, 1'b0);
        preload_memory();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(rows[r]);
        end
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : mem_prefetch_tb

// ==== mem_prefetch.f ====
verilog/mem_pkg.sv
verilog/prefetch_pkg.sv
verilog/fifo_prefetch.sv
verilog/read_pipe.sv
verilog/fetch_counter.sv
verilog/fetch_fsm.sv
verilog/mem_prefetch_top.sv
verification/tb_clock_gen.sv
verification/mem_prefetch_tb.sv

// ==== Makefile ====
# Verilator build and run for the memory read prefetcher

VERILATOR ?= verilator
TOP       ?= mem_prefetch_tb
FILELIST  ?= mem_prefetch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: sim clean

# Build, run, then pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
